// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= tb_addr_merge
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: addr_decode.sv
// address decode stage
// range-checks address beats, keeps one pending source selection, strobes on bad codes

`timescale 1ns/10ps

module addr_decode (
    input  logic     pclk,
    input  logic     prst_n,
    stream_if.sink   addr_in,
    stream_if.source sel_out,
    output logic     bad_addr
);

    // pending selection slot
    logic                      slot_full;
    merge_types_pkg::src_idx_t slot_idx;

    // handshake and decode terms
    logic addr_take;
    logic sel_take;
    logic addr_good;

    assign addr_take = addr_in.valid && addr_in.ready;
    assign sel_take  = sel_out.valid && sel_out.ready;

    // only codes below the source count name a source
    assign addr_good = addr_in.payload < merge_types_pkg::addr_t'(merge_cfg_pkg::NUM_SRC);

    // take a new address when the slot is empty or emptying on this edge
    assign addr_in.ready = !slot_full || sel_take;

    // slot drives the selection stream directly
    assign sel_out.valid   = slot_full;
    assign sel_out.payload = slot_idx;

    // slot occupancy
    // a good address fills it, a consumed selection with no refill frees it
    // a bad address leaves occupancy alone
    always_ff @(posedge pclk or negedge prst_n) begin
        if (!prst_n) begin
            slot_full <= 1'b0;
        end else if (addr_take && addr_good) begin
            slot_full <= 1'b1;
        end else if (sel_take) begin
            slot_full <= 1'b0;
        end
    end

    // selected index, loaded only from good addresses
    always_ff @(posedge pclk) begin
        if (addr_take && addr_good) begin
            slot_idx <= merge_types_pkg::src_idx_t'(addr_in.payload);
        end
    end

    // one-cycle strobe for each dropped address
    always_ff @(posedge pclk or negedge prst_n) begin
        if (!prst_n) begin
            bad_addr <= 1'b0;
        end else begin
            bad_addr <= addr_take && !addr_good;
        end
    end

endmodule

// File: addr_merge_top.sv
// address-steered stream merger top
// maps flat source, address and output ports onto streams and chains decode, steer, register

`timescale 1ns/10ps

module addr_merge_top (
    input  logic                                                pclk,
    input  logic                                                prst_n,
    // byte sources, source i in bits [i*DATA_W +: DATA_W]
    input  logic [merge_cfg_pkg::NUM_SRC-1:0]                   src_valid,
    output logic [merge_cfg_pkg::NUM_SRC-1:0]                   src_ready,
    input  logic [merge_cfg_pkg::NUM_SRC*merge_cfg_pkg::DATA_W-1:0] src_data,
    // address stream
    input  logic                                                addr_valid,
    output logic                                                addr_ready,
    input  merge_types_pkg::addr_t                              addr_data,
    // merged output
    output logic                                                out_valid,
    input  logic                                                out_ready,
    output merge_types_pkg::data_t                              out_data,
    output merge_types_pkg::src_idx_t                           out_src,
    // dropped address count
    output logic [merge_cfg_pkg::ERR_W-1:0]                     bad_addr_cnt
);

    // internal streams
    stream_if #(.payload_t(merge_types_pkg::addr_t))    addr_s ();
    stream_if #(.payload_t(merge_types_pkg::data_t))    src_s [merge_cfg_pkg::NUM_SRC-1:0] ();
    stream_if #(.payload_t(merge_types_pkg::src_idx_t)) sel_s ();
    stream_if #(.payload_t(merge_types_pkg::beat_t))    res_s ();

    // decode to output stage strobe
    logic bad_addr;

    // registered beat, split onto the flat output ports
    merge_types_pkg::beat_t out_beat;

    // address port onto its stream
    assign addr_s.valid   = addr_valid;
    assign addr_s.payload = addr_data;
    assign addr_ready     = addr_s.ready;

    // flat source ports onto one stream each
    for (genvar i = 0; i < merge_cfg_pkg::NUM_SRC; i++) begin : g_src
        assign src_s[i].valid   = src_valid[i];
        assign src_s[i].payload = src_data[i*merge_cfg_pkg::DATA_W +: merge_cfg_pkg::DATA_W];
        assign src_ready[i]     = src_s[i].ready;
    end

    addr_decode u_addr_decode (
        .pclk     (pclk),
        .prst_n   (prst_n),
        .addr_in  (addr_s),
        .sel_out  (sel_s),
        .bad_addr (bad_addr)
    );

    src_steer u_src_steer (
        .src_in  (src_s),
        .sel_in  (sel_s),
        .res_out (res_s)
    );

    out_stage u_out_stage (
        .pclk         (pclk),
        .prst_n       (prst_n),
        .res_in       (res_s),
        .bad_addr     (bad_addr),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_beat     (out_beat),
        .bad_addr_cnt (bad_addr_cnt)
    );

    assign out_data = out_beat.data;
    assign out_src  = out_beat.src;

endmodule

// File: merge_cfg_pkg.sv
// merge sizing package
// source count, payload widths and error counter width for the address-steered merger

package merge_cfg_pkg;

    // number of byte sources feeding the merger
    localparam int NUM_SRC = 5;

    // width of one source data byte
    localparam int DATA_W = 8;

    // address width, wide enough to carry the bad codes 5..7 as well
    localparam int ADDR_W = 3;

    // source index width carried on each output beat
    localparam int SRC_W = 3;

    // bad-address counter width
    // saturates at all ones
    localparam int ERR_W = 8;

endpackage

// File: merge_types_pkg.sv
// merge payload types
// typedefs for the address, data byte, source index and output beat payloads

package merge_types_pkg;

    // address as seen on the address stream
    // values at or above the source count name no source
    typedef logic [merge_cfg_pkg::ADDR_W-1:0] addr_t;

    // one byte from a source stream
    typedef logic [merge_cfg_pkg::DATA_W-1:0] data_t;

    // index of the source that delivered a beat
    typedef logic [merge_cfg_pkg::SRC_W-1:0] src_idx_t;

    // output beat, data in the upper bits and source tag below
    typedef struct packed {
        data_t    data;
        src_idx_t src;
    } beat_t;

endpackage

// File: out_stage.sv
// output register stage
// one-entry beat register that holds under back-pressure
// also keeps the saturating bad-address counter

`timescale 1ns/10ps

module out_stage (
    input  logic                             pclk,
    input  logic                             prst_n,
    stream_if.sink                           res_in,
    input  logic                             bad_addr,
    output logic                             out_valid,
    input  logic                             out_ready,
    output merge_types_pkg::beat_t           out_beat,
    output logic [merge_cfg_pkg::ERR_W-1:0]  bad_addr_cnt
);

    // handshake terms
    logic res_take;
    logic out_take;

    // counter already at all ones
    logic cnt_sat;

    assign res_take = res_in.valid && res_in.ready;
    assign out_take = out_valid && out_ready;

    // accept when empty or when the held beat leaves on this edge
    assign res_in.ready = !out_valid || out_ready;

    // occupancy of the output register
    always_ff @(posedge pclk or negedge prst_n) begin
        if (!prst_n) begin
            out_valid <= 1'b0;
        end else if (res_take) begin
            out_valid <= 1'b1;
        end else if (out_take) begin
            out_valid <= 1'b0;
        end
    end

    // beat payload, loaded only on accept so it holds while stalled
    always_ff @(posedge pclk) begin
        if (res_take) begin
            out_beat <= res_in.payload;
        end
    end

    assign cnt_sat = &bad_addr_cnt;

    // bad-address count
    // bumps in the cycle after each strobe, sticks at the top value
    always_ff @(posedge pclk or negedge prst_n) begin
        if (!prst_n) begin
            bad_addr_cnt <= '0;
        end else if (bad_addr && !cnt_sat) begin
            bad_addr_cnt <= bad_addr_cnt + 1'b1;
        end
    end

endmodule

// File: src_steer.sv
// source steering stage
// routes the selected source onto the result stream tagged with its index
// ready goes back only to that source, so source, selection and result move together

`timescale 1ns/10ps

module src_steer (
    stream_if.sink   src_in [merge_cfg_pkg::NUM_SRC-1:0],
    stream_if.sink   sel_in,
    stream_if.source res_out
);

    // flattened view of the source streams
    logic [merge_cfg_pkg::NUM_SRC-1:0] src_valid;
    merge_types_pkg::data_t            src_data [merge_cfg_pkg::NUM_SRC];

    // one-hot match of the pending selection against each source
    logic [merge_cfg_pkg::NUM_SRC-1:0] src_hit;

    // mux results
    logic                   pick_valid;
    merge_types_pkg::data_t pick_data;

    // result handshake, shared by all three streams
    logic res_take;

    // per-source unpack into flat valid and data vectors
    for (genvar i = 0; i < merge_cfg_pkg::NUM_SRC; i++) begin : g_src
        assign src_valid[i] = src_in[i].valid;
        assign src_data[i]  = src_in[i].payload;

        // a source is hit only while a selection is pending
        assign src_hit[i] = sel_in.valid &&
                            (sel_in.payload == merge_types_pkg::src_idx_t'(i));

        // non-selected sources always see ready low
        assign src_in[i].ready = src_hit[i] && res_out.ready;
    end

    // data/valid mux over all sources
    always_comb begin
        pick_valid = 1'b0;
        pick_data  = '0;
        for (int k = 0; k < merge_cfg_pkg::NUM_SRC; k++) begin
            if (src_hit[k]) begin
                pick_valid = src_valid[k];
                pick_data  = src_data[k];
            end
        end
    end

    // result valid waits for the chosen source, never looks at ready
    assign res_out.valid        = pick_valid;
    assign res_out.payload.data = pick_data;
    assign res_out.payload.src  = sel_in.payload;

    assign res_take = res_out.valid && res_out.ready;

    // selection retires on the same edge its source beat moves
    assign sel_in.ready = res_take;

endmodule

// File: stream_if.sv
// valid/ready stream interface
// payload type is a parameter so one bundle serves addresses, indices, bytes and beats

`timescale 1ns/10ps

interface stream_if #(
    parameter type payload_t = logic
) ();

    // producer has a beat on payload
    logic     valid;
    // consumer takes the beat on this edge when valid is also high
    logic     ready;
    // held stable while valid is high and ready is low
    payload_t payload;

    // producer side
    modport source (
        output valid,
        output payload,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

// File: tb_addr_merge.sv
// testbench for the address-steered stream merger
// directed tests over byte queues per source, an address queue and an expected beat queue

`timescale 1ns/10ps

module tb_addr_merge;

    localparam int NSRC    = merge_cfg_pkg::NUM_SRC;
    localparam int DW      = merge_cfg_pkg::DATA_W;
    localparam int SW      = merge_cfg_pkg::SRC_W;
    localparam int TIMEOUT = 200;

    // DUT ports
    logic                                pclk;
    logic                                prst_n;
    logic [NSRC-1:0]                     src_valid;
    logic [NSRC-1:0]                     src_ready;
    logic [NSRC*DW-1:0]                  src_data;
    logic                                addr_valid;
    logic                                addr_ready;
    merge_types_pkg::addr_t              addr_data;
    logic                                out_valid;
    logic                                out_ready;
    merge_types_pkg::data_t              out_data;
    merge_types_pkg::src_idx_t           out_src;
    logic [merge_cfg_pkg::ERR_W-1:0]     bad_addr_cnt;

    // model state
    // bytes each source still has to present, in order
    logic [DW-1:0]                       src_q [NSRC][$];
    // addresses still to be sent
    merge_types_pkg::addr_t              addr_q [$];
    // expected output beats as {data, source index}
    logic [DW+SW-1:0]                    exp_q [$];

    // per-source valid hold, used to stall one source
    logic [NSRC-1:0]                     src_hold = '0;
    // random out_ready when set
    logic                                bp_mode = 1'b0;
    int                                  seed = 12;

    addr_merge_top u_dut (
        .pclk         (pclk),
        .prst_n       (prst_n),
        .src_valid    (src_valid),
        .src_ready    (src_ready),
        .src_data     (src_data),
        .addr_valid   (addr_valid),
        .addr_ready   (addr_ready),
        .addr_data    (addr_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data),
        .out_src      (out_src),
        .bad_addr_cnt (bad_addr_cnt)
    );

    // 100 ns clock
    initial begin
        pclk = 1'b0;
        forever begin
            #50 pclk = ~pclk;
        end
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_fault(input string why);
        $display("error: %s", why);
        abort_run();
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("ERR %s exp %0h got %0h", name, exp, got);
            abort_run();
        end
    endtask

    // true once every queued address, byte and beat has gone through
    function automatic logic model_empty();
        logic empty;
        empty = (addr_q.size() == 0) && (exp_q.size() == 0);
        for (int i = 0; i < NSRC; i++) begin
            if (src_q[i].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    // queue one address; a good one also gets a fresh byte on its source
    task automatic push_addr(input merge_types_pkg::addr_t a);
        logic [DW-1:0] b;
        int            rnd;
        if (a < NSRC) begin
            rnd = $random(seed);
            b   = rnd[DW-1:0];
            src_q[a].push_back(b);
            exp_q.push_back({b, merge_types_pkg::src_idx_t'(a)});
        end
        addr_q.push_back(a);
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (!model_empty()) begin
            @(posedge pclk);
            n++;
            if (n > TIMEOUT) begin
                report_fault($sformatf("%s did not drain within %0d cycles", what, TIMEOUT));
            end
        end
    endtask

    task automatic wait_out_valid(input string what);
        int n;
        n = 0;
        @(negedge pclk);
        while (!out_valid) begin
            @(negedge pclk);
            n++;
            if (n > TIMEOUT) begin
                report_fault($sformatf("no output beat for %s within %0d cycles", what, TIMEOUT));
            end
        end
    endtask

    // driver and output monitor
    // handshakes are sampled at the falling edge, inputs change 10 ns after the rising edge
    initial begin : drive_loop
        logic [NSRC-1:0]           src_fire;
        logic                      addr_fire;
        logic                      out_fire;
        logic                      stall_prev;
        merge_types_pkg::data_t    held_data;
        merge_types_pkg::src_idx_t held_src;
        logic [DW+SW-1:0]          exp_beat;
        int                        rnd;
        src_valid  = '0;
        src_data   = '0;
        addr_valid = 1'b0;
        addr_data  = '0;
        out_ready  = 1'b0;
        stall_prev = 1'b0;
        held_data  = '0;
        held_src   = '0;
        forever begin
            @(negedge pclk);
            src_fire  = src_valid & src_ready;
            addr_fire = addr_valid && addr_ready;
            out_fire  = out_valid && out_ready;
            // a beat that was refused must still be there, unchanged
            if (stall_prev) begin
                check_val("out_valid", 1, out_valid);
                check_val("out_data", held_data, out_data);
                check_val("out_src", held_src, out_src);
            end
            stall_prev = out_valid && !out_ready;
            held_data  = out_data;
            held_src   = out_src;
            if (out_fire) begin
                if (exp_q.size() == 0) begin
                    report_fault("output beat appeared with no address waiting for it");
                end
                exp_beat = exp_q.pop_front();
                check_val("out_data", exp_beat[DW+SW-1:SW], out_data);
                check_val("out_src", exp_beat[SW-1:0], out_src);
            end
            @(posedge pclk);
            #10;
            // retire what moved on this edge, then present the next heads
            for (int i = 0; i < NSRC; i++) begin
                if (src_fire[i]) begin
                    void'(src_q[i].pop_front());
                end
                src_valid[i]          = !src_hold[i] && (src_q[i].size() > 0);
                src_data[i*DW +: DW]  = (src_q[i].size() > 0) ? src_q[i][0] : '0;
            end
            if (addr_fire) begin
                void'(addr_q.pop_front());
            end
            addr_valid = addr_q.size() > 0;
            addr_data  = (addr_q.size() > 0) ? addr_q[0] : '0;
            if (bp_mode) begin
                rnd       = $random(seed);
                out_ready = rnd[0];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    task automatic test_reset();
        @(negedge pclk);
        check_val("out_valid", 0, out_valid);
        check_val("src_ready", 0, src_ready);
        check_val("addr_ready", 1, addr_ready);
        check_val("bad_addr_cnt", 0, bad_addr_cnt);
    endtask

    // 20 addresses spread over all sources
    task automatic test_steering(input logic bp);
        bp_mode = bp;
        for (int i = 0; i < 20; i++) begin
            push_addr(merge_types_pkg::addr_t'((i * 3 + i / 5) % NSRC));
        end
        wait_drained(bp ? "back-pressure sequence" : "steering sequence");
        bp_mode = 1'b0;
    endtask

    task automatic test_bad_addr();
        logic [31:0] cnt0;
        @(negedge pclk);
        cnt0 = 32'(bad_addr_cnt);
        push_addr(3'd0);
        push_addr(3'd5);
        push_addr(3'd1);
        push_addr(3'd2);
        push_addr(3'd6);
        push_addr(3'd3);
        push_addr(3'd7);
        push_addr(3'd4);
        push_addr(3'd2);
        wait_drained("mixed good and bad addresses");
        // strobe one cycle after the drop, count one cycle after that
        repeat (3) @(negedge pclk);
        check_val("bad_addr_cnt", cnt0 + 3, bad_addr_cnt);
    endtask

    task automatic test_src_stall();
        logic [NSRC-1:0] others;
        others      = ~(NSRC'(1) << 2);
        src_hold[2] = 1'b1;
        push_addr(3'd2);
        push_addr(3'd0);
        push_addr(3'd1);
        push_addr(3'd3);
        push_addr(3'd4);
        // source 2 is silent, so nothing may move
        repeat (12) begin
            @(negedge pclk);
            check_val("out_valid", 0, out_valid);
            check_val("src_ready", 0, src_ready & others);
        end
        src_hold[2] = 1'b0;
        wait_out_valid("released source");
        check_val("out_src", 2, out_src);
        wait_drained("stalled source sequence");
    endtask

    // 260 bad addresses in four batches of 65, well past the counter top
    task automatic test_saturation();
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < 65; i++) begin
                push_addr(merge_types_pkg::addr_t'(5 + i % 3));
            end
            wait_drained("bad address batch");
        end
        repeat (3) @(negedge pclk);
        check_val("bad_addr_cnt", 255, bad_addr_cnt);
    endtask

    initial begin
        prst_n = 1'b0;
        repeat (16) @(posedge pclk);
        #10;
        prst_n = 1'b1;
        test_reset();
        test_steering(1'b0);
        test_steering(1'b1);
        test_bad_addr();
        test_src_stall();
        test_saturation();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: verilog.f
merge_cfg_pkg.sv
merge_types_pkg.sv
stream_if.sv
addr_decode.sv
src_steer.sv
out_stage.sv
addr_merge_top.sv
tb_addr_merge.sv
